/* rtl/fetch_pkg.sv */
// fetch and decode package
// word and table sizes, instruction views, decode encodings, stage structs
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////
	localparam int xlen           = 32;                        // machine word
	localparam int areg_bits      = 5;                         // architectural reg index
	localparam int btb_index_bits = 4;                         // 16 entries, pc[5:2]
	localparam int btb_tag_bits   = xlen - btb_index_bits - 2; // pc[31:6]
	localparam int hist_bits      = 4;                         // local and global history
	localparam int lht_index_bits = 4;                         // 16 local histories, pc[5:2]
	localparam logic [areg_bits-1:0] zero_reg = '0;            // x0, no writeback

	// rv32i major opcodes
	localparam logic [6:0] op_lui      = 7'b0110111;
	localparam logic [6:0] op_auipc    = 7'b0010111;
	localparam logic [6:0] op_jal      = 7'b1101111;
	localparam logic [6:0] op_jalr     = 7'b1100111;
	localparam logic [6:0] op_branch   = 7'b1100011;
	localparam logic [6:0] op_load     = 7'b0000011;
	localparam logic [6:0] op_store    = 7'b0100011;
	localparam logic [6:0] op_imm      = 7'b0010011;
	localparam logic [6:0] op_op       = 7'b0110011;
	localparam logic [6:0] op_misc_mem = 7'b0001111; // fence
	localparam logic [6:0] op_system   = 7'b1110011; // ecall, ebreak, csr

	////////////////////////////////////////////////////////////
	// instruction views, one word read per format
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_hi;                      // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;                      // imm[4:0]
		logic [6:0] opcode;
	} s_view_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_view_t;

	typedef struct packed {
		logic [19:0] imm;                        // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_view_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
		s_view_t s;
		b_view_t b;
		u_view_t u;
		j_view_t j;
	} inst_t;

	////////////////////////////////////////////////////////////
	// decode encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {opa_is_rs1, opa_is_pc, opa_is_zero} opa_sel_t;

	typedef enum logic [2:0] {
		opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_b_imm, opb_is_u_imm, opb_is_j_imm
	} opb_sel_t;

	typedef enum logic [4:0] {
		alu_add = 5'h00, alu_sub = 5'h01, alu_slt = 5'h02, alu_sltu = 5'h03,
		alu_and = 5'h04, alu_or = 5'h05, alu_xor = 5'h06, alu_sll = 5'h07,
		alu_srl = 5'h08, alu_sra = 5'h09,
		alu_mul = 5'h10, alu_mulh = 5'h11, alu_mulhsu = 5'h12, alu_mulhu = 5'h13, // 2'b10, funct3
		alu_div = 5'h14, alu_divu = 5'h15, alu_rem = 5'h16, alu_remu = 5'h17
	} alu_func_t;

	typedef enum logic [1:0] {fu_alu, fu_mult, fu_mem, fu_branch} fu_type_t; // rs_full index

	typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_t; // funct3[1:0]

	typedef enum logic {dest_rd, dest_none} dest_sel_t;

	////////////////////////////////////////////////////////////
	// stage structs
	////////////////////////////////////////////////////////////
	typedef struct packed {
		opa_sel_t  opa_select;
		opb_sel_t  opb_select;
		alu_func_t alu_func;
		fu_type_t  fu_type;
		dest_sel_t dest_select;
		logic      rd_mem;
		logic      wr_mem;
		mem_size_t mem_size;
		logic      load_signed;
		logic      cond_branch;
		logic      uncond_branch;
		logic      csr_op;
		logic      halt;                       // ecall, ebreak
		logic      illegal;
		logic      valid_inst;
	} decode_t;

	typedef struct packed {
		logic            valid;                // one-cycle strobe
		logic [xlen-1:0] pc;
		logic [xlen-1:0] target_pc;            // resolved next pc
		logic            cond_branch;
		logic            uncond_branch;
		logic            taken;
		logic            local_taken;          // predictions it was fetched with
		logic            global_taken;
		logic            mis_pred;
	} resolve_t;

	typedef struct packed {
		logic                 valid;
		inst_t                inst;
		logic [xlen-1:0]      pc;
		logic [xlen-1:0]      npc;
		decode_t              ctrl;
		logic [areg_bits-1:0] opa_areg_idx;
		logic [areg_bits-1:0] opb_areg_idx;
		logic [areg_bits-1:0] dest_areg_idx;
		logic                 branch_prediction;
		logic                 local_taken;
		logic                 global_taken;
	} id_packet_t;

endpackage

`default_nettype wire

/* rtl/inst_decoder.sv */
// rv32i instruction decoder
// combinational, turns one fetched word into the control fields of the packet
`default_nettype none

module inst_decoder (
	input  fetch_pkg::inst_t   inst,
	output fetch_pkg::decode_t ctrl
);
	import fetch_pkg::*;

	// shared funct3 table of OP and OP-IMM, alt picks sub / sra
	function automatic alu_func_t base_alu(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  base_alu = alt ? alu_sub : alu_add;
			3'b001:  base_alu = alu_sll;
			3'b010:  base_alu = alu_slt;
			3'b011:  base_alu = alu_sltu;
			3'b100:  base_alu = alu_xor;
			3'b101:  base_alu = alt ? alu_sra : alu_srl;
			3'b110:  base_alu = alu_or;
			default: base_alu = alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl             = '0;                 // no mem, no branch, legal
		ctrl.opa_select  = opa_is_rs1;
		ctrl.opb_select  = opb_is_rs2;
		ctrl.alu_func    = alu_add;
		ctrl.fu_type     = fu_alu;
		ctrl.dest_select = dest_none;
		ctrl.mem_size    = mem_word;

		case (inst.r.opcode)
			op_lui: begin
				ctrl.opa_select  = opa_is_zero;  // 0 + imm
				ctrl.opb_select  = opb_is_u_imm;
				ctrl.dest_select = dest_rd;
			end
			op_auipc: begin
				ctrl.opa_select  = opa_is_pc;
				ctrl.opb_select  = opb_is_u_imm;
				ctrl.dest_select = dest_rd;
			end
			op_jal: begin
				ctrl.opa_select    = opa_is_pc;
				ctrl.opb_select    = opb_is_j_imm;
				ctrl.fu_type       = fu_branch;
				ctrl.dest_select   = dest_rd;    // link
				ctrl.uncond_branch = 1'b1;
			end
			op_jalr: begin
				ctrl.opb_select    = opb_is_i_imm;
				ctrl.fu_type       = fu_branch;
				ctrl.dest_select   = dest_rd;
				ctrl.uncond_branch = 1'b1;
				ctrl.illegal       = inst.i.funct3 != 3'b000;
			end
			op_branch: begin
				ctrl.opa_select  = opa_is_pc;    // target = pc + imm
				ctrl.opb_select  = opb_is_b_imm;
				ctrl.fu_type     = fu_branch;
				ctrl.cond_branch = 1'b1;
				ctrl.illegal     = inst.b.funct3[2:1] == 2'b01; // 010, 011 unused
			end
			op_load: begin
				ctrl.opb_select  = opb_is_i_imm;
				ctrl.fu_type     = fu_mem;
				ctrl.dest_select = dest_rd;
				ctrl.rd_mem      = 1'b1;
				ctrl.mem_size    = mem_size_t'(inst.i.funct3[1:0]);
				ctrl.load_signed = !inst.i.funct3[2]; // lbu, lhu zero extend
				ctrl.illegal     = inst.i.funct3[1:0] == 2'b11 || inst.i.funct3 == 3'b110;
			end
			op_store: begin
				ctrl.opb_select = opb_is_s_imm;
				ctrl.fu_type    = fu_mem;
				ctrl.wr_mem     = 1'b1;
				ctrl.mem_size   = mem_size_t'(inst.s.funct3[1:0]);
				ctrl.illegal    = inst.s.funct3 > 3'b010;
			end
			op_imm: begin
				ctrl.opb_select  = opb_is_i_imm;
				ctrl.dest_select = dest_rd;
				ctrl.alu_func    = base_alu(inst.i.funct3,
					inst.i.funct3 == 3'b101 && inst.r.funct7[5]); // srai
				if (inst.i.funct3 == 3'b001)     // slli shamt only
					ctrl.illegal = inst.r.funct7 != 7'h00;
				else if (inst.i.funct3 == 3'b101)
					ctrl.illegal = (inst.r.funct7 & 7'b1011111) != 7'h00;
			end
			op_op: begin
				ctrl.dest_select = dest_rd;
				if (inst.r.funct7 == 7'h01) begin
					ctrl.fu_type  = fu_mult;     // multiply group, unit only
					ctrl.alu_func = alu_func_t'({2'b10, inst.r.funct3});
				end else if (inst.r.funct7 == 7'h00) begin
					ctrl.alu_func = base_alu(inst.r.funct3, 1'b0);
				end else if (inst.r.funct7 == 7'h20) begin
					ctrl.alu_func = base_alu(inst.r.funct3, 1'b1);
					ctrl.illegal  = inst.r.funct3 != 3'b000 && inst.r.funct3 != 3'b101;
				end else begin
					ctrl.illegal = 1'b1;
				end
			end
			op_misc_mem: begin
				ctrl.alu_func = alu_add;         // fence issues as a nop
			end
			op_system: begin
				if (inst.i.funct3 != 3'b000) begin
					ctrl.csr_op      = 1'b1;
					ctrl.dest_select = dest_rd;
					ctrl.illegal     = inst.i.funct3 == 3'b100;
				end else begin
					ctrl.halt    = inst.i.imm == 12'h000 || inst.i.imm == 12'h001;
					ctrl.illegal = !ctrl.halt;   // mret, wfi not supported
				end
			end
			default: ctrl.illegal = 1'b1;
		endcase

		ctrl.valid_inst = !ctrl.illegal;
	end

endmodule

`default_nettype wire

/* rtl/branch_target_buffer.sv */
// branch target buffer
// direct-mapped tagged table of taken-branch targets, read by the fetch pc
`default_nettype none

module branch_target_buffer (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [fetch_pkg::xlen-1:0] pc,
	input  logic                       update,        // taken branch resolved
	input  logic [fetch_pkg::xlen-1:0] update_pc,
	input  logic [fetch_pkg::xlen-1:0] update_target,
	output logic                       hit,
	output logic [fetch_pkg::xlen-1:0] target
);
	import fetch_pkg::*;

	typedef struct packed {
		logic [btb_tag_bits-1:0] tag;            // pc[31:6]
		logic [xlen-1:0]         target;
	} entry_t;

	logic [2**btb_index_bits-1:0] valid_bits;
	entry_t                       entry_mem [2**btb_index_bits];
	logic [btb_index_bits-1:0]    rd_idx;
	logic [btb_index_bits-1:0]    wr_idx;
	entry_t                       rd_entry;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////
	assign rd_idx   = pc[btb_index_bits+1:2];    // word index
	assign wr_idx   = update_pc[btb_index_bits+1:2];
	assign rd_entry = entry_mem[rd_idx];
	assign hit      = valid_bits[rd_idx] && rd_entry.tag == pc[xlen-1:btb_index_bits+2];
	assign target   = rd_entry.target;

	////////////////////////////////////////////////////////////
	// training, seen by lookups from the next cycle on
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset)
			valid_bits <= '0;
		else if (update)
			valid_bits[wr_idx] <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (update) begin
			entry_mem[wr_idx].tag    <= update_pc[xlen-1:btb_index_bits+2];
			entry_mem[wr_idx].target <= update_target; // latest target wins
		end
	end

endmodule

`default_nettype wire

/* rtl/tournament_predictor.sv */
// tournament branch predictor
// local and global two-bit counter tables with a per-pc chooser
`default_nettype none

module tournament_predictor (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [fetch_pkg::xlen-1:0] pc,
	input  logic                       update,        // resolved cond branch
	input  logic [fetch_pkg::xlen-1:0] update_pc,
	input  logic                       taken_actual,
	input  logic                       local_was,     // predictions at fetch time
	input  logic                       global_was,
	output logic                       predict_taken,
	output logic                       local_taken,
	output logic                       global_taken
);
	import fetch_pkg::*;

	logic [hist_bits-1:0]      lht [2**lht_index_bits];     // local histories
	logic [1:0]                local_pht [2**hist_bits];
	logic [1:0]                global_pht [2**hist_bits];
	logic [1:0]                chooser [2**lht_index_bits]; // 2, 3 pick global
	logic [hist_bits-1:0]      ghr;
	logic [lht_index_bits-1:0] rd_idx;
	logic [lht_index_bits-1:0] wr_idx;
	logic [hist_bits-1:0]      wr_local_hist;

	// two-bit saturating step
	function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic up);
		if (up)
			sat_step = (ctr == 2'd3) ? ctr : ctr + 2'd1;
		else
			sat_step = (ctr == 2'd0) ? ctr : ctr - 2'd1;
	endfunction

	////////////////////////////////////////////////////////////
	// prediction
	////////////////////////////////////////////////////////////
	assign rd_idx        = pc[lht_index_bits+1:2];
	assign local_taken   = local_pht[lht[rd_idx]][1];  // msb set means taken
	assign global_taken  = global_pht[ghr][1];
	assign predict_taken = chooser[rd_idx][1] ? global_taken : local_taken;

	////////////////////////////////////////////////////////////
	// training
	////////////////////////////////////////////////////////////
	assign wr_idx        = update_pc[lht_index_bits+1:2];
	assign wr_local_hist = lht[wr_idx];           // history before this outcome

	always_ff @(posedge clock) begin
		if (reset) begin
			ghr <= '0;
			for (int n = 0; n < 2**hist_bits; n++) begin
				local_pht[n]  <= 2'd1;            // weakly not taken
				global_pht[n] <= 2'd1;
			end
			for (int n = 0; n < 2**lht_index_bits; n++) begin
				lht[n]     <= '0;
				chooser[n] <= 2'd1;               // weakly local
			end
		end else if (update) begin
			local_pht[wr_local_hist] <= sat_step(local_pht[wr_local_hist], taken_actual);
			global_pht[ghr]          <= sat_step(global_pht[ghr], taken_actual);
			lht[wr_idx]              <= {wr_local_hist[hist_bits-2:0], taken_actual};
			ghr                      <= {ghr[hist_bits-2:0], taken_actual};
			// chooser moves only when the two paths disagreed
			if (local_was != global_was)
				chooser[wr_idx] <= sat_step(chooser[wr_idx], global_was == taken_actual);
		end
	end

endmodule

`default_nettype wire

/* rtl/fetch_decode_stage.sv */
// fetch and decode stage
// pc register, next pc choice, stall and redirect, decode packet to issue
`default_nettype none

module fetch_decode_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       rob_full,
	input  logic [3:0]                 rs_full,    // indexed by fu_type
	input  fetch_pkg::inst_t           imem_data,
	input  logic                       imem_valid,
	input  fetch_pkg::resolve_t        result,
	output logic [fetch_pkg::xlen-1:0] imem_addr,
	output fetch_pkg::id_packet_t      id_packet
);
	import fetch_pkg::*;

	logic [xlen-1:0] pc;                         // pc being fetched
	logic [xlen-1:0] pc_plus_4;
	logic [xlen-1:0] npc;
	decode_t         ctrl;
	logic            btb_hit;
	logic [xlen-1:0] btb_target;
	logic            predict_taken;
	logic            local_taken;
	logic            global_taken;
	logic            mispredict;
	logic            predictor_update;
	logic            btb_update;
	logic            take_target;
	logic            packet_valid;

	////////////////////////////////////////////////////////////
	// decode and prediction
	////////////////////////////////////////////////////////////
	inst_decoder u_decoder (
		.inst (imem_data),
		.ctrl (ctrl)
	);

	assign predictor_update = result.valid && result.cond_branch;
	assign btb_update       = result.valid && result.taken
		&& (result.cond_branch || result.uncond_branch);

	branch_target_buffer u_btb (
		.clock         (clock),
		.reset         (reset),
		.pc            (pc),
		.update        (btb_update),
		.update_pc     (result.pc),
		.update_target (result.target_pc),
		.hit           (btb_hit),
		.target        (btb_target)
	);

	tournament_predictor u_predictor (
		.clock         (clock),
		.reset         (reset),
		.pc            (pc),
		.update        (predictor_update),
		.update_pc     (result.pc),
		.taken_actual  (result.taken),
		.local_was     (result.local_taken),
		.global_was    (result.global_taken),
		.predict_taken (predict_taken),
		.local_taken   (local_taken),
		.global_taken  (global_taken)
	);

	////////////////////////////////////////////////////////////
	// next pc and stall
	////////////////////////////////////////////////////////////
	assign pc_plus_4    = pc + 32'd4;
	assign take_target  = btb_hit && (ctrl.uncond_branch || (ctrl.cond_branch && predict_taken));
	assign npc          = take_target ? btb_target : pc_plus_4;
	assign mispredict   = result.valid && result.mis_pred;
	assign packet_valid = imem_valid && !mispredict && !rob_full && !rs_full[ctrl.fu_type];
	assign imem_addr    = {pc[xlen-1:2], 2'b00}; // word aligned

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (mispredict)
			pc <= result.target_pc;              // redirect from execute
		else if (packet_valid)
			pc <= npc;                           // otherwise hold and refetch
	end

	// packet to issue
	always_comb begin
		id_packet.valid             = packet_valid;
		id_packet.inst              = imem_data;
		id_packet.pc                = pc;
		id_packet.npc               = npc;
		id_packet.ctrl              = ctrl;
		id_packet.opa_areg_idx      = imem_data.r.rs1;
		id_packet.opb_areg_idx      = imem_data.r.rs2;
		id_packet.dest_areg_idx     = (ctrl.dest_select == dest_rd) ? imem_data.r.rd : zero_reg;
		id_packet.branch_prediction = btb_hit && predict_taken;
		id_packet.local_taken       = local_taken;
		id_packet.global_taken      = global_taken;
	end

endmodule

`default_nettype wire

/* dv/fetch_decode_tb.sv */
// fetch and decode stage testbench
// random fetch, stall and resolve traffic against a reference pc, predictor and btb
`default_nettype none

module fetch_decode_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fetch_pkg::*;

	localparam int clock_period = 100;
	localparam int reset_cycles = 3;
	localparam int num_cycles   = 3000;
	localparam int mem_words    = 64;                  // addressed by imem_addr[7:2]
	localparam int btb_entries  = 2**btb_index_bits;

	logic            clock = 1'b0;                     // low from the start, no edge at time 0
	logic            reset;
	logic            rob_full;
	logic [3:0]      rs_full;
	inst_t           imem_data;
	logic            imem_valid;
	resolve_t        result;
	logic [xlen-1:0] imem_addr;
	id_packet_t      id_packet;

	inst_t  imem [mem_words];
	integer seed;
	int     checks;
	int     packet_errors;
	int     addr_errors;
	int     bit_errors;

	// reference state, as it stands after the coming edge
	logic [xlen-1:0]         m_pc;
	logic                    m_btb_valid [btb_entries];
	logic [btb_tag_bits-1:0] m_btb_tag [btb_entries];
	logic [xlen-1:0]         m_btb_target [btb_entries];
	logic [hist_bits-1:0]    m_lht [2**lht_index_bits];
	logic [1:0]              m_local_pht [2**hist_bits];
	logic [1:0]              m_global_pht [2**hist_bits];
	logic [1:0]              m_chooser [2**lht_index_bits];
	logic [hist_bits-1:0]    m_ghr;

	fetch_decode_stage dut (
		.clock      (clock),
		.reset      (reset),
		.rob_full   (rob_full),
		.rs_full    (rs_full),
		.imem_data  (imem_data),
		.imem_valid (imem_valid),
		.result     (result),
		.imem_addr  (imem_addr),
		.id_packet  (id_packet)
	);

	assign imem_data = imem[imem_addr[7:2]];           // same-cycle memory

	initial begin
		forever #(clock_period / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// reference functions
	////////////////////////////////////////////////////////////
	function automatic alu_func_t alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? alu_sub : alu_add;
			3'd1:    return alu_sll;
			3'd2:    return alu_slt;
			3'd3:    return alu_sltu;
			3'd4:    return alu_xor;
			3'd5:    return alt ? alu_sra : alu_srl;
			3'd6:    return alu_or;
			default: return alu_and;
		endcase
	endfunction

	// m extension funct3 table
	function automatic alu_func_t mult_of(input logic [2:0] f3);
		case (f3)
			3'd0:    return alu_mul;
			3'd1:    return alu_mulh;
			3'd2:    return alu_mulhsu;
			3'd3:    return alu_mulhu;
			3'd4:    return alu_div;
			3'd5:    return alu_divu;
			3'd6:    return alu_rem;
			default: return alu_remu;
		endcase
	endfunction

	function automatic decode_t ref_decode(input inst_t w);
		decode_t    d;
		logic [2:0] f3;
		logic [6:0] f7;
		f3            = w.r.funct3;
		f7            = w.r.funct7;
		d             = '0;
		d.opa_select  = opa_is_rs1;
		d.opb_select  = opb_is_rs2;
		d.alu_func    = alu_add;
		d.fu_type     = fu_alu;
		d.dest_select = dest_none;
		d.mem_size    = mem_word;
		case (w.r.opcode)
			op_lui: begin
				d.opa_select  = opa_is_zero;
				d.opb_select  = opb_is_u_imm;
				d.dest_select = dest_rd;
			end
			op_auipc: begin
				d.opa_select  = opa_is_pc;
				d.opb_select  = opb_is_u_imm;
				d.dest_select = dest_rd;
			end
			op_misc_mem: ;                                  // fence, plain alu nop
			op_imm: begin
				d.opb_select  = opb_is_i_imm;
				d.dest_select = dest_rd;
				d.alu_func    = alu_of(f3, f3 == 3'd5 && f7[5]);
				d.illegal     = (f3 == 3'd1 && f7 != 7'h00)
					|| (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20); // bad shift encodings
			end
			op_op: begin
				d.dest_select = dest_rd;
				if (f7 == 7'h01) begin
					d.fu_type  = fu_mult;
					d.alu_func = mult_of(f3);
				end else if (f7 == 7'h00 || f7 == 7'h20) begin
					d.alu_func = alu_of(f3, f7[5]);
					d.illegal  = f7[5] && f3 != 3'd0 && f3 != 3'd5; // only sub, sra
				end else begin
					d.illegal = 1'b1;
				end
			end
			op_load: begin
				d.opb_select  = opb_is_i_imm;
				d.fu_type     = fu_mem;
				d.dest_select = dest_rd;
				d.rd_mem      = 1'b1;
				d.mem_size    = mem_size_t'(f3[1:0]);
				d.load_signed = !f3[2];
				d.illegal     = !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5);
			end
			op_store: begin
				d.opb_select = opb_is_s_imm;
				d.fu_type    = fu_mem;
				d.wr_mem     = 1'b1;
				d.mem_size   = mem_size_t'(f3[1:0]);
				d.illegal    = f3 > 3'd2;
			end
			op_branch: begin
				d.opa_select  = opa_is_pc;
				d.opb_select  = opb_is_b_imm;
				d.fu_type     = fu_branch;
				d.cond_branch = 1'b1;
				d.illegal     = f3 == 3'd2 || f3 == 3'd3;
			end
			op_jal: begin
				d.opa_select    = opa_is_pc;
				d.opb_select    = opb_is_j_imm;
				d.fu_type       = fu_branch;
				d.dest_select   = dest_rd;
				d.uncond_branch = 1'b1;
			end
			op_jalr: begin
				d.opb_select    = opb_is_i_imm;            // rs1 + imm
				d.fu_type       = fu_branch;
				d.dest_select   = dest_rd;
				d.uncond_branch = 1'b1;
				d.illegal       = f3 != 3'd0;
			end
			op_system: begin
				if (f3 != 3'd0) begin
					d.csr_op      = 1'b1;
					d.dest_select = dest_rd;
					d.illegal     = f3 == 3'd4;
				end else begin
					d.halt    = w.i.imm <= 12'h001;            // ecall, ebreak
					d.illegal = !d.halt;
				end
			end
			default: d.illegal = 1'b1;
		endcase
		d.valid_inst = !d.illegal;
		return d;
	endfunction

	function automatic logic [1:0] counter_step(input logic [1:0] c, input logic up);
		if (up && c != 2'd3)
			return c + 2'd1;
		if (!up && c != 2'd0)
			return c - 2'd1;
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_packet(input id_packet_t exp, input id_packet_t act);
		checks++;
		if (act !== exp) begin
			packet_errors++;
			$display("mismatch id_packet at %0t: expected %h, got %h", $time, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		checks++;
		if (act !== exp) begin
			addr_errors++;
			$display("mismatch %s at %0t: expected %h, got %h", name, $time, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			bit_errors++;
			$display("mismatch %s at %0t: expected %h, got %h", name, $time, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	task automatic reset_model;
		m_pc  = '0;
		m_ghr = '0;
		for (int n = 0; n < btb_entries; n++)
			m_btb_valid[n] = 1'b0;
		for (int n = 0; n < 2**hist_bits; n++) begin
			m_local_pht[n]  = 2'd1;
			m_global_pht[n] = 2'd1;
		end
		for (int n = 0; n < 2**lht_index_bits; n++) begin
			m_lht[n]     = '0;
			m_chooser[n] = 2'd1;
		end
	endtask

	task automatic train_model(input resolve_t r);
		logic [lht_index_bits-1:0] idx;
		logic [hist_bits-1:0]      h;
		idx = r.pc[lht_index_bits+1:2];
		h   = m_lht[idx];                                // history before this outcome
		if (r.cond_branch) begin
			m_local_pht[h]      = counter_step(m_local_pht[h], r.taken);
			m_global_pht[m_ghr] = counter_step(m_global_pht[m_ghr], r.taken);
			m_lht[idx]          = {h[hist_bits-2:0], r.taken};
			m_ghr               = {m_ghr[hist_bits-2:0], r.taken};
			if (r.local_taken != r.global_taken)
				m_chooser[idx] = counter_step(m_chooser[idx], r.global_taken == r.taken);
		end
		if (r.taken && (r.cond_branch || r.uncond_branch)) begin
			m_btb_valid[idx]  = 1'b1;                    // same pc[5:2] index
			m_btb_tag[idx]    = r.pc[xlen-1:btb_index_bits+2];
			m_btb_target[idx] = r.target_pc;
		end
	endtask

	task automatic check_cycle;
		inst_t                     w;
		decode_t                   d;
		id_packet_t                e;
		logic [btb_index_bits-1:0] idx;
		logic                      hit;
		logic                      pt;
		logic                      mp;
		w   = imem[m_pc[7:2]];
		d   = ref_decode(w);
		idx = m_pc[btb_index_bits+1:2];
		hit = m_btb_valid[idx] && m_btb_tag[idx] == m_pc[xlen-1:btb_index_bits+2];
		mp  = result.valid && result.mis_pred;
		e.local_taken       = m_local_pht[m_lht[idx]][1];
		e.global_taken      = m_global_pht[m_ghr][1];
		pt                  = m_chooser[idx][1] ? e.global_taken : e.local_taken;
		e.valid             = imem_valid && !mp && !rob_full && !rs_full[d.fu_type];
		e.inst              = w;
		e.pc                = m_pc;
		e.npc               = (hit && (d.uncond_branch || (d.cond_branch && pt)))
			? m_btb_target[idx] : m_pc + 32'd4;
		e.ctrl              = d;
		e.opa_areg_idx      = w.r.rs1;
		e.opb_areg_idx      = w.r.rs2;
		e.dest_areg_idx     = (d.dest_select == dest_rd) ? w.r.rd : zero_reg;
		e.branch_prediction = hit && pt;
		check_addr("imem_addr", m_pc, imem_addr);
		check_bit("id_packet.valid", e.valid, id_packet.valid);
		check_bit("branch_prediction", e.branch_prediction, id_packet.branch_prediction);
		check_packet(e, id_packet);
		// advance to the state after the next edge
		if (mp)
			m_pc = result.target_pc;
		else if (e.valid)
			m_pc = e.npc;
		if (result.valid)
			train_model(result);
	endtask

	always @(negedge clock) begin                     // outputs settled here
		if (reset)
			reset_model();
		else
			check_cycle();
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	// rarer opcodes, one per slot 7 word
	function automatic inst_t misc_word(input int n, input logic [31:0] r);
		case (n)
			0:       return {r[31:7], op_lui};
			2:       return {r[31:7], op_auipc};
			4:       return {r[31:7], op_jalr};
			6:       return {r[31:7], op_misc_mem};
			7:       return {r[31:7], 7'h00};              // no such opcode
			default: return {r[31:7], op_system};
		endcase
	endfunction

	task automatic fill_memory;
		logic [31:0] r;
		for (int i = 0; i < mem_words; i++) begin
			r = $random(seed);
			case (i % 8)
				0: imem[i] = {r[31:7], op_imm};
				1: imem[i] = {1'b0, r[30], 5'b0, r[24:7], op_op}; // funct7 0 or 0x20
				2: imem[i] = {r[31:7], op_load};                   // any width, some illegal
				3: imem[i] = {r[31:15], 1'b0, r[13:7], op_store};
				4: imem[i] = {7'h01, r[24:7], op_op};             // multiply group
				5: imem[i] = {r[31:7], op_branch};
				6: imem[i] = (i % 16 == 6) ? {r[31:7], op_jal}
					: (r[0] ? 32'h0010_0073 : 32'h0000_0073);     // ebreak, ecall
				default: imem[i] = misc_word(i / 8, r);
			endcase
		end
	endtask

	task automatic drive_inputs;
		resolve_t r;
		decode_t  d;
		r                = '0;
		r.valid          = ($random(seed) & 3) == 0;
		r.pc             = $random(seed) & 32'h0000_00fc; // inside the memory
		d                = ref_decode(imem[r.pc[7:2]]);
		r.cond_branch    = d.cond_branch;
		r.uncond_branch  = d.uncond_branch;
		r.taken          = d.uncond_branch || (($random(seed) & 3) != 0); // mostly taken
		r.target_pc      = $random(seed) & 32'h0000_00fc;
		r.local_taken    = ($random(seed) & 1) != 0;
		r.global_taken   = ($random(seed) & 1) != 0;
		r.mis_pred       = (d.cond_branch || d.uncond_branch) && (($random(seed) & 7) == 0);
		result          <= r;
		imem_valid      <= ($random(seed) & 7) != 0;
		rob_full        <= ($random(seed) & 15) == 0;
		for (int n = 0; n < 4; n++)
			rs_full[n] <= ($random(seed) & 7) == 0;
	endtask

	initial begin
		seed          = 32'h3e39;
		checks        = 0;
		packet_errors = 0;
		addr_errors   = 0;
		bit_errors    = 0;
		reset         = 1'b1;
		rob_full      = 1'b0;
		rs_full       = '0;
		imem_valid    = 1'b0;
		result        = '0;
		fill_memory();
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		repeat (num_cycles) begin
			@(posedge clock);
			drive_inputs();
		end
		repeat (2) @(posedge clock);                     // last compares done
		$display("checks %0d, errors: packet %0d, address %0d, bit %0d",
			checks, packet_errors, addr_errors, bit_errors);
		if (packet_errors + addr_errors + bit_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#((reset_cycles + num_cycles + 50) * clock_period);
		$display("watchdog timeout, the run did not reach its end in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/fetch_pkg.sv
rtl/inst_decoder.sv
rtl/branch_target_buffer.sv
rtl/tournament_predictor.sv
rtl/fetch_decode_stage.sv
dv/fetch_decode_tb.sv

/* Bender.yml */
package:
  name: fetch_decode

sources:
  - rtl/fetch_pkg.sv
  - rtl/inst_decoder.sv
  - rtl/branch_target_buffer.sv
  - rtl/tournament_predictor.sv
  - rtl/fetch_decode_stage.sv
  - target: test
    files:
      - dv/fetch_decode_tb.sv
